/* logic/proc_consts.svh */
/*
 * Widths, reset PC and CSR numbers shared by the processor
 */
`ifndef PROC_CONSTS_SVH
`define PROC_CONSTS_SVH

// Data path and instruction word width
`define XLEN 32

// Register specifier width
`define REG_ADDR_W 5

// First fetch address out of reset
`define RESET_PC 32'h0000_0200

// CSR number for words sent to the manager
`define CSR_PROC2MNGR 12'h7C0

// CSR number for words read from the manager
`define CSR_MNGR2PROC 12'hFC0

`endif

/* logic/isa_pkg.sv */
/*
 * TinyRV2 subset encodings and the instruction word views
 */
`include "proc_consts.svh"

package isa_pkg;

  // Major opcodes kept in this core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // ALU funct3 shared by reg-reg and reg-imm forms
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Branch and CSR funct3
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_CSRW = 3'b001;
  localparam logic [2:0] F3_CSRR = 3'b010;

  // funct7 that turns ADD into SUB
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // R-format view
  typedef struct packed {
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    opcode_e                opcode;
  } inst_r_t;

  // I-format view whose imm12 also carries the CSR number
  typedef struct packed {
    logic [11:0]            imm12;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    opcode_e                opcode;
  } inst_i_t;

  // One fetched word read through either view
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_u;

endpackage

/* logic/pipe_pkg.sv */
/*
 * Pipeline control enums and stage-to-stage records
 */
`include "proc_consts.svh"

package pipe_pkg;

  // ALU operations where CP2 passes operand 2 through
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_AND,
    ALU_OR,
    ALU_CP2
  } alu_fn_e;

  // Writeback value source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_PC4,
    WB_MNGR
  } wb_sel_e;

  // Fetch to decode
  typedef struct packed {
    logic               valid;
    logic [`XLEN-1:0]   pc;
    isa_pkg::inst_u     inst;
  } fd_t;

  // Decode to execute
  typedef struct packed {
    logic                   valid;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       op1;
    logic [`XLEN-1:0]       op2;
    logic [`XLEN-1:0]       rs2_data;
    alu_fn_e                alu_fn;
    wb_sel_e                wb_sel;
    logic                   branch;
    logic [`XLEN-1:0]       target;
    logic                   wen;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   mngr;
  } dx_t;

  // Execute to writeback
  typedef struct packed {
    logic                   valid;
    logic [`XLEN-1:0]       result;
    logic                   wen;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   mngr;
  } xw_t;

  // Pending destination seen by decode
  typedef struct packed {
    logic                   live;
    logic [`REG_ADDR_W-1:0] rd;
  } dest_t;

  // PC redirect request
  typedef struct packed {
    logic               taken;
    logic [`XLEN-1:0]   target;
  } redirect_t;

  // Register file write port
  typedef struct packed {
    logic                   en;
    logic [`REG_ADDR_W-1:0] addr;
    logic [`XLEN-1:0]       data;
  } rf_wr_t;

endpackage

/* logic/proc_fetch.sv */
/*
 * Fetch stage with the PC register, redirect select and instruction memory address
 */
`timescale 1ns/1ps
`include "proc_consts.svh"

module proc_fetch (
  input  logic                clk,
  input  logic                reset,
  input  logic                stall_d_i,
  input  pipe_pkg::redirect_t br_redirect_i,
  input  pipe_pkg::redirect_t jal_redirect_i,
  output logic [`XLEN-1:0]    imem_addr_o,
  input  logic [`XLEN-1:0]    imem_data_i,
  output pipe_pkg::fd_t       fd_o
);

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] pc_next;
  logic             squash;

  // Branch in execute wins over JAL in decode
  always_comb begin
    if (br_redirect_i.taken) begin
      pc_next = br_redirect_i.target;
    end else if (jal_redirect_i.taken) begin
      pc_next = jal_redirect_i.target;
    end else if (stall_d_i) begin
      pc_next = pc_q;
    end else begin
      pc_next = pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= `RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  // Memory answers in the same cycle
  assign imem_addr_o = pc_q;

  // Either redirect kills the word fetched this cycle
  assign squash = br_redirect_i.taken || jal_redirect_i.taken;

  assign fd_o.valid = !squash;
  assign fd_o.pc    = pc_q;
  assign fd_o.inst  = imem_data_i;

endmodule

/* logic/proc_decode.sv */
/*
 * Decode stage with its stage register, control table, immediates,
 * hazard and manager-input stalls and the JAL redirect
 */
`timescale 1ns/1ps
`include "proc_consts.svh"

module proc_decode (
  input  logic                   clk,
  input  logic                   reset,
  input  pipe_pkg::fd_t          fd_i,
  input  logic                   stall_w_i,
  input  pipe_pkg::redirect_t    br_redirect_i,
  input  pipe_pkg::dest_t        x_dest_i,
  input  pipe_pkg::dest_t        w_dest_i,
  output logic [`REG_ADDR_W-1:0] rs1_addr_o,
  output logic [`REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [`XLEN-1:0]       rs1_data_i,
  input  logic [`XLEN-1:0]       rs2_data_i,
  input  logic [`XLEN-1:0]       mngr2proc_data_i,
  input  logic                   mngr2proc_val_i,
  output logic                   mngr2proc_rdy_o,
  output logic                   stall_d_o,
  output pipe_pkg::redirect_t    jal_redirect_o,
  output pipe_pkg::dx_t          dx_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  // Operand 2 source
  typedef enum logic [1:0] {
    OP2_RS2,
    OP2_IMM,
    OP2_MNGR,
    OP2_RS1
  } op2_sel_e;

  fd_t              fd_q;
  inst_u            inst;
  logic [`XLEN-1:0] word;
  logic             rs1_en;
  logic             rs2_en;
  logic             wen;
  logic             branch;
  logic             jal;
  logic             csrr;
  logic             csrw;
  op2_sel_e         op2_sel;
  alu_fn_e          alu_fn;
  wb_sel_e          wb_sel;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] target;
  logic             hazard;
  logic             mngr_wait;
  logic             squash;

  // Same funct3 map for reg-reg and reg-imm
  function automatic alu_fn_e f3_alu(input logic [2:0] f3);
    case (f3)
      F3_ADD:  return ALU_ADD;
      F3_XOR:  return ALU_XOR;
      F3_OR:   return ALU_OR;
      F3_AND:  return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  function automatic logic dest_hit(input dest_t d, input logic [`REG_ADDR_W-1:0] addr);
    return d.live && (d.rd == addr);
  endfunction

  // ------------------------------------------------
  // Stage register
  // ------------------------------------------------

  // A taken branch overrides the stall since the slot arrives already squashed
  always_ff @(posedge clk) begin
    if (reset) begin
      fd_q.valid <= 1'b0;
    end else if (!stall_d_o || br_redirect_i.taken) begin
      fd_q <= fd_i;
    end
  end

  assign inst = fd_q.inst;
  assign word = fd_q.inst;

  // ------------------------------------------------
  // Control table
  // ------------------------------------------------

  always_comb begin
    rs1_en  = 1'b0;
    rs2_en  = 1'b0;
    wen     = 1'b0;
    branch  = 1'b0;
    jal     = 1'b0;
    csrr    = 1'b0;
    csrw    = 1'b0;
    op2_sel = OP2_RS2;
    alu_fn  = ALU_ADD;
    wb_sel  = WB_ALU;
    case (inst.r.opcode)
      OPC_OP: begin
        rs1_en = 1'b1;
        rs2_en = 1'b1;
        wen    = 1'b1;
        if (inst.r.funct3 == F3_ADD && inst.r.funct7 == F7_SUB) begin
          alu_fn = ALU_SUB;
        end else begin
          alu_fn = f3_alu(inst.r.funct3);
        end
      end
      OPC_OP_IMM: begin
        // NOP lands here as ADDI to x0
        rs1_en  = 1'b1;
        wen     = 1'b1;
        op2_sel = OP2_IMM;
        alu_fn  = f3_alu(inst.i.funct3);
      end
      OPC_BRANCH: begin
        branch = (inst.r.funct3 == F3_BNE);
        rs1_en = branch;
        rs2_en = branch;
      end
      OPC_JAL: begin
        jal    = 1'b1;
        wen    = 1'b1;
        wb_sel = WB_PC4;
      end
      OPC_SYSTEM: begin
        csrr   = (inst.i.funct3 == F3_CSRR) && (inst.i.imm12 == `CSR_MNGR2PROC);
        csrw   = (inst.i.funct3 == F3_CSRW) && (inst.i.imm12 == `CSR_PROC2MNGR);
        rs1_en = csrw;
        wen    = csrr;
        alu_fn = ALU_CP2;
        if (csrr) begin
          op2_sel = OP2_MNGR;
          wb_sel  = WB_MNGR;
        end else begin
          op2_sel = OP2_RS1;
        end
      end
      default: begin
        // Unsupported words retire as no-ops
      end
    endcase
  end

  // Immediates
  assign imm_i = {{20{inst.i.imm12[11]}}, inst.i.imm12};
  assign imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
  assign imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};

  // One adder for the JAL and BNE targets
  assign target = fd_q.pc + (jal ? imm_j : imm_b);

  assign rs1_addr_o = inst.r.rs1;
  assign rs2_addr_o = inst.r.rs2;

  // ------------------------------------------------
  // Stalls and redirect
  // ------------------------------------------------

  // Wait until the producer has left writeback
  assign hazard = (rs1_en && (dest_hit(x_dest_i, inst.r.rs1) ||
                              dest_hit(w_dest_i, inst.r.rs1))) ||
                  (rs2_en && (dest_hit(x_dest_i, inst.r.rs2) ||
                              dest_hit(w_dest_i, inst.r.rs2)));

  assign mngr_wait = csrr && !mngr2proc_val_i;
  assign squash    = br_redirect_i.taken;
  assign stall_d_o = stall_w_i || (fd_q.valid && (hazard || mngr_wait));

  // Input word taken only when nothing else holds the CSRR
  assign mngr2proc_rdy_o = fd_q.valid && csrr && !hazard && !stall_w_i && !squash;

  assign jal_redirect_o.taken  = fd_q.valid && jal && !stall_d_o && !squash;
  assign jal_redirect_o.target = target;

  // Bubble goes out when stalled or squashed
  always_comb begin
    dx_o.valid = fd_q.valid && !stall_d_o && !squash;
    dx_o.pc    = fd_q.pc;
    dx_o.op1   = rs1_data_i;
    case (op2_sel)
      OP2_IMM:  dx_o.op2 = imm_i;
      OP2_MNGR: dx_o.op2 = mngr2proc_data_i;
      OP2_RS1:  dx_o.op2 = rs1_data_i;
      default:  dx_o.op2 = rs2_data_i;
    endcase
    dx_o.rs2_data = rs2_data_i;
    dx_o.alu_fn   = alu_fn;
    dx_o.wb_sel   = wb_sel;
    dx_o.branch   = branch;
    dx_o.target   = target;
    dx_o.wen      = wen;
    dx_o.rd       = inst.r.rd;
    dx_o.mngr     = csrw;
  end

endmodule

/* logic/proc_regfile.sv */
/*
 * Register file with two read ports and one write port
 */
`timescale 1ns/1ps
`include "proc_consts.svh"

module proc_regfile (
  input  logic                   clk,
  input  pipe_pkg::rf_wr_t       wr_i,
  input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
  output logic [`XLEN-1:0]       rs1_data_o,
  output logic [`XLEN-1:0]       rs2_data_o
);

  logic [`XLEN-1:0] regs [(1 << `REG_ADDR_W)];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (wr_i.en && (wr_i.addr != '0)) begin
      regs[wr_i.addr] <= wr_i.data;
    end
  end

  // Combinational reads with x0 forced to zero
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* logic/proc_execute.sv */
/*
 * Execute stage with its stage register, ALU, BNE resolution and link value
 */
`timescale 1ns/1ps
`include "proc_consts.svh"

module proc_execute (
  input  logic                clk,
  input  logic                reset,
  input  pipe_pkg::dx_t       dx_i,
  input  logic                stall_w_i,
  output pipe_pkg::redirect_t br_redirect_o,
  output pipe_pkg::dest_t     x_dest_o,
  output pipe_pkg::xw_t       xw_o
);
  import pipe_pkg::*;

  dx_t              dx_q;
  logic [`XLEN-1:0] alu_out;
  logic [`XLEN-1:0] pc_plus4;

  // Moves only when writeback moves
  always_ff @(posedge clk) begin
    if (reset) begin
      dx_q.valid <= 1'b0;
    end else if (!stall_w_i) begin
      dx_q <= dx_i;
    end
  end

  // ------------------------------------------------
  // ALU
  // ------------------------------------------------

  always_comb begin
    case (dx_q.alu_fn)
      ALU_SUB: alu_out = dx_q.op1 - dx_q.op2;
      ALU_XOR: alu_out = dx_q.op1 ^ dx_q.op2;
      ALU_AND: alu_out = dx_q.op1 & dx_q.op2;
      ALU_OR:  alu_out = dx_q.op1 | dx_q.op2;
      ALU_CP2: alu_out = dx_q.op2;
      default: alu_out = dx_q.op1 + dx_q.op2;
    endcase
  end

  assign pc_plus4 = dx_q.pc + 32'd4;

  // Taken BNE is held back while the stage is stalled
  assign br_redirect_o.taken  = dx_q.valid && dx_q.branch &&
                                (dx_q.op1 != dx_q.rs2_data) && !stall_w_i;
  assign br_redirect_o.target = dx_q.target;

  // Destination for decode hazard checks
  assign x_dest_o.live = dx_q.valid && dx_q.wen && (dx_q.rd != '0);
  assign x_dest_o.rd   = dx_q.rd;

  always_comb begin
    xw_o.valid = dx_q.valid;
    case (dx_q.wb_sel)
      WB_PC4:  xw_o.result = pc_plus4;
      WB_MNGR: xw_o.result = dx_q.op2;
      default: xw_o.result = alu_out;
    endcase
    xw_o.wen  = dx_q.wen;
    xw_o.rd   = dx_q.rd;
    xw_o.mngr = dx_q.mngr;
  end

endmodule

/* logic/proc_result.sv */
/*
 * Writeback stage with its stage register, register write and manager output
 */
`timescale 1ns/1ps
`include "proc_consts.svh"

module proc_result (
  input  logic              clk,
  input  logic              reset,
  input  pipe_pkg::xw_t     xw_i,
  output logic [`XLEN-1:0]  proc2mngr_data_o,
  output logic              proc2mngr_val_o,
  input  logic              proc2mngr_rdy_i,
  output logic              stall_w_o,
  output pipe_pkg::dest_t   w_dest_o,
  output pipe_pkg::rf_wr_t  wr_o
);
  import pipe_pkg::*;

  xw_t xw_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      xw_q.valid <= 1'b0;
    end else if (!stall_w_o) begin
      xw_q <= xw_i;
    end
  end

  // Output word waits here for the manager
  assign stall_w_o = xw_q.valid && xw_q.mngr && !proc2mngr_rdy_i;

  // val and data stay put until the transfer
  assign proc2mngr_val_o  = xw_q.valid && xw_q.mngr;
  assign proc2mngr_data_o = xw_q.result;

  // Written once as the instruction leaves
  assign wr_o.en   = xw_q.valid && xw_q.wen && !stall_w_o;
  assign wr_o.addr = xw_q.rd;
  assign wr_o.data = xw_q.result;

  assign w_dest_o.live = xw_q.valid && xw_q.wen && (xw_q.rd != '0);
  assign w_dest_o.rd   = xw_q.rd;

endmodule

/* logic/proc_top.sv */
/*
 * Processor top level joining fetch, decode, execute, writeback and the register file
 */
`timescale 1ns/1ps
`include "proc_consts.svh"

module proc_top (
  input  logic             clk,
  input  logic             reset,
  output logic [`XLEN-1:0] imem_addr_o,
  input  logic [`XLEN-1:0] imem_data_i,
  input  logic [`XLEN-1:0] mngr2proc_data_i,
  input  logic             mngr2proc_val_i,
  output logic             mngr2proc_rdy_o,
  output logic [`XLEN-1:0] proc2mngr_data_o,
  output logic             proc2mngr_val_o,
  input  logic             proc2mngr_rdy_i
);
  import pipe_pkg::*;

  // ------------------------------------------------
  // Stage records and control
  // ------------------------------------------------

  fd_t                    fd;
  dx_t                    dx;
  xw_t                    xw;
  rf_wr_t                 wr;
  dest_t                  x_dest;
  dest_t                  w_dest;
  redirect_t              br_redirect;
  redirect_t              jal_redirect;
  logic                   stall_w;
  logic                   stall_d;
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;

  proc_fetch i_fetch (
    .clk            (clk),
    .reset          (reset),
    .stall_d_i      (stall_d),
    .br_redirect_i  (br_redirect),
    .jal_redirect_i (jal_redirect),
    .imem_addr_o    (imem_addr_o),
    .imem_data_i    (imem_data_i),
    .fd_o           (fd)
  );

  proc_decode i_decode (
    .clk              (clk),
    .reset            (reset),
    .fd_i             (fd),
    .stall_w_i        (stall_w),
    .br_redirect_i    (br_redirect),
    .x_dest_i         (x_dest),
    .w_dest_i         (w_dest),
    .rs1_addr_o       (rs1_addr),
    .rs2_addr_o       (rs2_addr),
    .rs1_data_i       (rs1_data),
    .rs2_data_i       (rs2_data),
    .mngr2proc_data_i (mngr2proc_data_i),
    .mngr2proc_val_i  (mngr2proc_val_i),
    .mngr2proc_rdy_o  (mngr2proc_rdy_o),
    .stall_d_o        (stall_d),
    .jal_redirect_o   (jal_redirect),
    .dx_o             (dx)
  );

  proc_regfile i_regfile (
    .clk        (clk),
    .wr_i       (wr),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  proc_execute i_execute (
    .clk           (clk),
    .reset         (reset),
    .dx_i          (dx),
    .stall_w_i     (stall_w),
    .br_redirect_o (br_redirect),
    .x_dest_o      (x_dest),
    .xw_o          (xw)
  );

  proc_result i_result (
    .clk              (clk),
    .reset            (reset),
    .xw_i             (xw),
    .proc2mngr_data_o (proc2mngr_data_o),
    .proc2mngr_val_o  (proc2mngr_val_o),
    .proc2mngr_rdy_i  (proc2mngr_rdy_i),
    .stall_w_o        (stall_w),
    .w_dest_o         (w_dest),
    .wr_o             (wr)
  );

endmodule

/* verif/tb_clock.sv */
/*
 * Testbench clock source
 */
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_PERIOD_NS = 50
) (
  output logic clk_o
);

  // 100 ns period by default
  initial clk_o = 1'b0;

  always #(HALF_PERIOD_NS) clk_o = ~clk_o;

endmodule

/* verif/proc_tb.sv */
/*
 * Processor testbench with the ROM program, manager streams, expected-word model,
 * assertions and timeout
 */
`timescale 1ns/1ps
`include "proc_consts.svh"

module proc_tb;
  import isa_pkg::*;

  localparam int N_IN        = 3;
  localparam int ROM_WORDS   = 64;
  localparam int LOOP_MAX    = 7;
  localparam int WORST_CPI   = 16;
  localparam int RESET_CYC   = 16;
  localparam int MAX_CYCLES  = (ROM_WORDS + 3 * LOOP_MAX) * WORST_CPI + RESET_CYC;
  localparam logic [31:0] NOP = 32'h0000_0013;

  logic             clk;
  logic             reset;
  logic [31:0]      imem_addr_o;
  logic [31:0]      imem_data_i;
  logic [31:0]      mngr2proc_data_i;
  logic             mngr2proc_val_i;
  logic             mngr2proc_rdy_o;
  logic [31:0]      proc2mngr_data_o;
  logic             proc2mngr_val_o;
  logic             proc2mngr_rdy_i;

  logic [31:0]      rom [ROM_WORDS];
  int               prog_len;
  logic [31:0]      jal_pc;
  logic [31:0]      in_words [N_IN];
  int               in_idx;
  logic [31:0]      exp_q [$];
  logic [31:0]      lfsr;
  int               cycles;
  logic             hold_pending;
  logic [31:0]      held_data;

  tb_clock i_clock (.clk_o(clk));

  proc_top i_dut (
    .clk              (clk),
    .reset            (reset),
    .imem_addr_o      (imem_addr_o),
    .imem_data_i      (imem_data_i),
    .mngr2proc_data_i (mngr2proc_data_i),
    .mngr2proc_val_i  (mngr2proc_val_i),
    .mngr2proc_rdy_o  (mngr2proc_rdy_o),
    .proc2mngr_data_o (proc2mngr_data_o),
    .proc2mngr_val_o  (proc2mngr_val_o),
    .proc2mngr_rdy_i  (proc2mngr_rdy_i)
  );

  // ------------------------------------------------
  // Error reports and random bits
  // ------------------------------------------------

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // Galois LFSR stepped once per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // ------------------------------------------------
  // Instruction encoders
  // ------------------------------------------------

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [11:0] imm,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_bne(input logic [12:0] off, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {off[12], off[10:5], rs2, rs1, F3_BNE, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [31:0] csrr(input logic [4:0] rd);
    return enc_i(OPC_SYSTEM, `CSR_MNGR2PROC, 5'd0, F3_CSRR, rd);
  endfunction

  function automatic logic [31:0] csrw(input logic [4:0] rs1);
    return enc_i(OPC_SYSTEM, `CSR_PROC2MNGR, rs1, F3_CSRW, 5'd0);
  endfunction

  task automatic emit(input logic [31:0] w);
    rom[prog_len] = w;
    prog_len++;
  endtask

  // ------------------------------------------------
  // Program and expected words
  // ------------------------------------------------

  task automatic build_program();
    for (int k = 0; k < ROM_WORDS; k++) rom[k] = NOP;
    prog_len = 0;
    // Dependent ALU chain on two input words
    emit(csrr(5'd1));
    emit(csrr(5'd2));
    emit(enc_r(7'd0, 5'd2, 5'd1, F3_ADD, 5'd3));
    emit(csrw(5'd3));
    emit(enc_r(F7_SUB, 5'd1, 5'd3, F3_ADD, 5'd4));
    emit(csrw(5'd4));
    emit(enc_r(7'd0, 5'd2, 5'd4, F3_XOR, 5'd5));
    emit(csrw(5'd5));
    emit(enc_r(7'd0, 5'd1, 5'd5, F3_AND, 5'd6));
    emit(csrw(5'd6));
    emit(enc_r(7'd0, 5'd3, 5'd6, F3_OR, 5'd7));
    emit(csrw(5'd7));
    emit(enc_i(OPC_OP_IMM, 12'(-300), 5'd7, F3_ADD, 5'd8));
    emit(csrw(5'd8));
    emit(enc_i(OPC_OP_IMM, 12'h555, 5'd8, F3_XOR, 5'd9));
    emit(csrw(5'd9));
    emit(enc_i(OPC_OP_IMM, 12'hFF0, 5'd9, F3_OR, 5'd9));
    emit(csrw(5'd9));
    emit(enc_i(OPC_OP_IMM, 12'h3C3, 5'd9, F3_AND, 5'd9));
    emit(csrw(5'd9));
    emit(NOP);
    // Countdown loop over a count of 1 to 7
    emit(csrr(5'd10));
    emit(enc_i(OPC_OP_IMM, 12'd7, 5'd10, F3_AND, 5'd10));
    emit(enc_i(OPC_OP_IMM, 12'd1, 5'd10, F3_OR, 5'd10));
    emit(enc_i(OPC_OP_IMM, 12'd0, 5'd0, F3_ADD, 5'd11));
    emit(enc_i(OPC_OP_IMM, 12'h5A5, 5'd0, F3_ADD, 5'd13));
    emit(enc_i(OPC_OP_IMM, 12'hFFF, 5'd10, F3_ADD, 5'd10));
    emit(enc_i(OPC_OP_IMM, 12'd1, 5'd11, F3_ADD, 5'd11));
    emit(enc_bne(13'(-8), 5'd10, 5'd0));
    // Exit branch is always taken with markers in its shadow
    emit(enc_bne(13'd12, 5'd11, 5'd0));
    emit(csrw(5'd13));
    emit(csrw(5'd13));
    emit(csrw(5'd11));
    // JAL skips one marker and links into x14
    jal_pc = `RESET_PC + 32'(4 * prog_len);
    emit(enc_jal(21'd8, 5'd14));
    emit(csrw(5'd13));
    emit(csrw(5'd14));
    // x0 ignores the write
    emit(enc_i(OPC_OP_IMM, 12'd5, 5'd1, F3_ADD, 5'd0));
    emit(csrw(5'd0));
    emit(enc_jal(21'd0, 5'd0));
  endtask

  // Words the ISA rules give for the inputs sent
  task automatic build_expected();
    logic [31:0] a, b, x3, x4, x5, x6, x7, x8, x9;
    a  = in_words[0];
    b  = in_words[1];
    x3 = a + b;
    x4 = x3 - a;
    x5 = x4 ^ b;
    x6 = x5 & a;
    x7 = x6 | x3;
    x8 = x7 - 32'd300;
    x9 = x8 ^ 32'h0000_0555;
    exp_q = {x3, x4, x5, x6, x7, x8, x9};
    x9 = x9 | 32'hFFFF_FFF0;
    exp_q.push_back(x9);
    x9 = x9 & 32'h0000_03C3;
    exp_q.push_back(x9);
    exp_q.push_back((in_words[2] & 32'd7) | 32'd1);
    exp_q.push_back(jal_pc + 32'd4);
    exp_q.push_back(32'd0);
  endtask

  // Combinational ROM where words past the program read as NOP
  always_comb begin
    logic [31:0] idx;
    idx = (imem_addr_o - `RESET_PC) >> 2;
    imem_data_i = (idx < ROM_WORDS) ? rom[idx] : NOP;
  end

  // ------------------------------------------------
  // Stream drivers and output checks
  // ------------------------------------------------

  // Input words with random gaps and random back-pressure on the output
  always @(posedge clk) begin
    logic [31:0] r;
    if (!reset) begin
      if (mngr2proc_val_i && mngr2proc_rdy_o) in_idx = in_idx + 1;
      // val holds until the word is taken
      if (!(mngr2proc_val_i && !mngr2proc_rdy_o)) begin
        take_bits(2, r);
        if (in_idx < N_IN && r != 0) begin
          mngr2proc_val_i  <= 1'b1;
          mngr2proc_data_i <= in_words[in_idx];
        end else begin
          mngr2proc_val_i  <= 1'b0;
        end
      end
      // rdy low about a quarter of the time
      take_bits(2, r);
      proc2mngr_rdy_i <= (r != 0);
    end
  end

  always @(posedge clk) begin
    if (!reset) begin
      if (hold_pending) begin
        assert (proc2mngr_val_o && proc2mngr_data_o == held_data)
          else report_error("output val or data changed while rdy was low");
      end
      if (proc2mngr_val_o && proc2mngr_rdy_i) begin
        assert (exp_q.size() > 0)
          else report_error("processor sent a word after the last expected one");
        assert (proc2mngr_data_o == exp_q[0])
          else report_mismatch($sformatf("output %h, expected %h",
                                         proc2mngr_data_o, exp_q[0]));
        void'(exp_q.pop_front());
      end
      hold_pending = proc2mngr_val_o && !proc2mngr_rdy_i;
      held_data    = proc2mngr_data_o;
    end
  end

  // Cycle limit from program length and worst stall
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: pipeline did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  task automatic check_idle();
    assert (!proc2mngr_val_o && !mngr2proc_rdy_o && imem_addr_o == `RESET_PC)
      else report_mismatch("streams or fetch address not idle around reset");
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------

  initial begin
    logic [31:0] r;
    reset            = 1'b1;
    mngr2proc_data_i = '0;
    mngr2proc_val_i  = 1'b0;
    proc2mngr_rdy_i  = 1'b0;
    in_idx           = 0;
    cycles           = 0;
    hold_pending     = 1'b0;
    held_data        = '0;
    lfsr             = 32'd74538;
    build_program();
    for (int k = 0; k < N_IN; k++) begin
      take_bits(32, r);
      in_words[k] = r;
    end
    build_expected();
    // Last check falls in the first cycle after release
    for (int k = 0; k < RESET_CYC; k++) begin
      @(posedge clk);
      if (k == RESET_CYC - 1) reset <= 1'b0;
      @(negedge clk);
      check_idle();
    end
    while (exp_q.size() != 0) @(posedge clk);
    // Room for any stray word to show up
    repeat (20) @(posedge clk);
    if (in_idx == N_IN) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Error: %0d input words consumed, %0d expected", in_idx, N_IN);
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

/* src.f */
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/proc_fetch.sv
logic/proc_decode.sv
logic/proc_regfile.sv
logic/proc_execute.sv
logic/proc_result.sv
logic/proc_top.sv
verif/tb_clock.sv
verif/proc_tb.sv

/* Makefile */
# Verilator flow for the pipelined processor

VERILATOR ?= verilator
TOP       ?= proc_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
PASS_STR  ?= Simulation passed
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard logic/*.sv logic/*.svh verif/*.sv)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The run passes only if the pass line shows up in the output
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_STR)"

clean:
	rm -rf $(BUILD_DIR)
